// ==== logic/roce_pkg.sv ====
////////////////////
// RoCE command glue shared definitions
// Widths, request/ack field positions and enums
////////////////////
package roce_pkg;

    // Field widths
    localparam int RDMA_OPCODE_BITS = 5;
    localparam int RDMA_QPN_BITS    = 24;
    localparam int RDMA_VADDR_BITS  = 48;
    localparam int RDMA_LEN_BITS    = 32;
    localparam int RDMA_REQ_BITS    = 128;
    localparam int RDMA_ACK_BITS    = 64;

    // Flow control
    localparam int MAX_OUTSTANDING  = 8;
    localparam int CREDIT_BITS      = 4;

    // Register port
    localparam int CFG_ADDR_BITS    = 2;
    localparam int CFG_DATA_BITS    = 32;

    ////////////////////
    // Request word layout (lsb positions)
    localparam int REQ_OPCODE_LSB   = 0;
    localparam int REQ_QPN_LSB      = 8;
    localparam int REQ_LAST_LSB     = 32;
    localparam int REQ_VADDR_LSB    = 40;
    localparam int REQ_LEN_LSB      = 88;

    // Ack word layout with the upper bits unused
    localparam int ACK_OPCODE_LSB   = 0;
    localparam int ACK_QPN_LSB      = 8;
    localparam int ACK_LAST_LSB     = 32;

    ////////////////////
    // IB base transport opcodes for the RC requests we issue
    typedef enum logic [RDMA_OPCODE_BITS-1:0] {
        RC_SEND      = 5'h04,
        RC_WRITE     = 5'h0A,
        RC_WRITE_IMM = 5'h0B,
        RC_READ      = 5'h0C
    } rdma_opcode_e;

    typedef enum logic [RDMA_OPCODE_BITS-1:0] {
        ACK_POS = 5'h00,
        ACK_NAK = 5'h01
    } ack_opcode_e;

    typedef enum logic [CFG_ADDR_BITS-1:0] {
        REG_CREDIT_LIMIT = 2'd0,
        REG_REQ_COUNT    = 2'd1,
        REG_ACK_COUNT    = 2'd2,
        REG_NAK_COUNT    = 2'd3
    } reg_addr_e;

endpackage

// ==== logic/sq_intf.sv ====
////////////////////
// Send-queue command channel, flow control to packer
////////////////////
`timescale 1ns/1ps

interface sq_intf
    import roce_pkg::*;
();

    logic                       valid;
    logic                       ready;
    rdma_opcode_e               opcode;
    logic [RDMA_QPN_BITS-1:0]   qpn;
    logic [RDMA_VADDR_BITS-1:0] vaddr;
    logic [RDMA_LEN_BITS-1:0]   len;
    logic                       last;

    // Command source
    modport src (output valid, opcode, qpn, vaddr, len, last, input ready);

    // Command sink
    modport dst (input valid, opcode, qpn, vaddr, len, last, output ready);

endinterface

// ==== logic/rdma_flow_ctrl.sv ====
////////////////////
// Credit-based admission of user send-queue commands
// Tracks requests in flight toward the protocol engine
////////////////////
`timescale 1ns/1ps

module rdma_flow_ctrl
    import roce_pkg::*;
(
    input  logic                       nclk,
    input  logic                       arst_n,

    // User command
    input  logic                       sq_valid,
    output logic                       sq_ready,
    input  rdma_opcode_e               sq_opcode,
    input  logic [RDMA_QPN_BITS-1:0]   sq_qpn,
    input  logic [RDMA_VADDR_BITS-1:0] sq_vaddr,
    input  logic [RDMA_LEN_BITS-1:0]   sq_len,
    input  logic                       sq_last,

    // Toward packer
    sq_intf.src                        sq,

    // Credits
    input  logic [CREDIT_BITS-1:0]     credit_limit,
    input  logic                       credit_return,
    output logic                       req_issued
);

    logic [CREDIT_BITS-1:0] in_flight;
    logic                   credit_free;

    // Limit of 0 never admits; a lowered limit stalls until acks drain
    assign credit_free = (in_flight < credit_limit);

    assign sq.valid  = sq_valid && credit_free;
    assign sq_ready  = credit_free && sq.ready;

    assign sq.opcode = sq_opcode;
    assign sq.qpn    = sq_qpn;
    assign sq.vaddr  = sq_vaddr;
    assign sq.len    = sq_len;
    assign sq.last   = sq_last;

    assign req_issued = sq.valid && sq.ready;

    ////////////////////
    // In-flight counter
    always_ff @(posedge nclk or negedge arst_n) begin
        if (!arst_n) begin
            in_flight <= '0;
        end else begin
            case ({req_issued, credit_return})
                2'b10:   in_flight <= in_flight + 1'b1;
                2'b01:   in_flight <= in_flight - 1'b1;
                // Issue and return together cancel out
                default: in_flight <= in_flight;
            endcase
        end
    end

endmodule

// ==== logic/sq_packer.sv ====
////////////////////
// One-entry stage packing commands into engine request words
////////////////////
`timescale 1ns/1ps

module sq_packer
    import roce_pkg::*;
(
    input  logic                     nclk,
    input  logic                     arst_n,

    sq_intf.dst                      sq,

    // Request word to the protocol engine
    output logic                     req_valid,
    input  logic                     req_ready,
    output logic [RDMA_REQ_BITS-1:0] req_data
);

    logic [RDMA_REQ_BITS-1:0] packed_word;
    logic                     load;

    // Accept when empty or the current word leaves this cycle
    assign sq.ready = !req_valid || req_ready;
    assign load     = sq.valid && sq.ready;

    // Unused bits stay zero
    always_comb begin
        packed_word = '0;
        packed_word[REQ_OPCODE_LSB +: RDMA_OPCODE_BITS] = sq.opcode;
        packed_word[REQ_QPN_LSB +: RDMA_QPN_BITS]       = sq.qpn;
        packed_word[REQ_LAST_LSB]                       = sq.last;
        packed_word[REQ_VADDR_LSB +: RDMA_VADDR_BITS]   = sq.vaddr;
        packed_word[REQ_LEN_LSB +: RDMA_LEN_BITS]       = sq.len;
    end

    always_ff @(posedge nclk or negedge arst_n) begin
        if (!arst_n) begin
            req_valid <= 1'b0;
        end else if (load) begin
            req_valid <= 1'b1;
        end else if (req_ready) begin
            req_valid <= 1'b0;
        end
    end

    // Payload only moves on a load, so it holds under back-pressure
    always_ff @(posedge nclk) begin
        if (load) begin
            req_data <= packed_word;
        end
    end

endmodule

// ==== logic/ack_unpacker.sv ====
////////////////////
// One-entry stage turning engine acks into user completions
////////////////////
`timescale 1ns/1ps

module ack_unpacker
    import roce_pkg::*;
(
    input  logic                     nclk,
    input  logic                     arst_n,

    // Ack word from the protocol engine
    input  logic                     ack_valid,
    output logic                     ack_ready,
    input  logic [RDMA_ACK_BITS-1:0] ack_data,

    // Completion to the user
    output logic                     cpl_valid,
    input  logic                     cpl_ready,
    output ack_opcode_e              cpl_opcode,
    output logic [RDMA_QPN_BITS-1:0] cpl_qpn,
    output logic                     cpl_last,

    // Events
    output logic                     credit_return,
    output logic                     ack_seen,
    output logic                     nak_seen
);

    ack_opcode_e ack_opcode;
    logic        accept;

    assign ack_opcode = ack_opcode_e'(ack_data[ACK_OPCODE_LSB +: RDMA_OPCODE_BITS]);

    // No acceptance, and so no credit back, while a completion is stuck
    assign ack_ready = !cpl_valid || cpl_ready;
    assign accept    = ack_valid && ack_ready;

    assign credit_return = accept;
    assign nak_seen      = accept && (ack_opcode == ACK_NAK);
    assign ack_seen      = accept && (ack_opcode != ACK_NAK);

    always_ff @(posedge nclk or negedge arst_n) begin
        if (!arst_n) begin
            cpl_valid <= 1'b0;
        end else if (accept) begin
            cpl_valid <= 1'b1;
        end else if (cpl_ready) begin
            cpl_valid <= 1'b0;
        end
    end

    always_ff @(posedge nclk) begin
        if (accept) begin
            cpl_opcode <= ack_opcode;
            cpl_qpn    <= ack_data[ACK_QPN_LSB +: RDMA_QPN_BITS];
            cpl_last   <= ack_data[ACK_LAST_LSB];
        end
    end

endmodule

// ==== logic/stack_regs.sv ====
////////////////////
// Credit limit and event counter registers
////////////////////
`timescale 1ns/1ps

module stack_regs
    import roce_pkg::*;
(
    input  logic                     nclk,
    input  logic                     arst_n,

    // Register port
    input  logic                     cfg_wr_en,
    input  reg_addr_e                cfg_addr,
    input  logic [CFG_DATA_BITS-1:0] cfg_wdata,
    output logic [CFG_DATA_BITS-1:0] cfg_rdata,

    output logic [CREDIT_BITS-1:0]   credit_limit,

    // Event pulses
    input  logic                     req_issued,
    input  logic                     ack_seen,
    input  logic                     nak_seen
);

    logic [CFG_DATA_BITS-1:0] req_count;
    logic [CFG_DATA_BITS-1:0] ack_count;
    logic [CFG_DATA_BITS-1:0] nak_count;

    ////////////////////
    // Writable limit, clamped
    always_ff @(posedge nclk or negedge arst_n) begin
        if (!arst_n) begin
            credit_limit <= CREDIT_BITS'(MAX_OUTSTANDING);
        end else if (cfg_wr_en && (cfg_addr == REG_CREDIT_LIMIT)) begin
            if (cfg_wdata > CFG_DATA_BITS'(MAX_OUTSTANDING)) begin
                credit_limit <= CREDIT_BITS'(MAX_OUTSTANDING);
            end else begin
                credit_limit <= cfg_wdata[CREDIT_BITS-1:0];
            end
        end
    end

    ////////////////////
    // Read-only counters
    always_ff @(posedge nclk or negedge arst_n) begin
        if (!arst_n) begin
            req_count <= '0;
            ack_count <= '0;
            nak_count <= '0;
        end else begin
            if (req_issued) req_count <= req_count + 1'b1;
            if (ack_seen)   ack_count <= ack_count + 1'b1;
            if (nak_seen)   nak_count <= nak_count + 1'b1;
        end
    end

    always_comb begin
        case (cfg_addr)
            REG_CREDIT_LIMIT: cfg_rdata = CFG_DATA_BITS'(credit_limit);
            REG_REQ_COUNT:    cfg_rdata = req_count;
            REG_ACK_COUNT:    cfg_rdata = ack_count;
            REG_NAK_COUNT:    cfg_rdata = nak_count;
            default:          cfg_rdata = '0;
        endcase
    end

endmodule

// ==== logic/roce_stack.sv ====
////////////////////
// RoCE command and ack glue top level
// Flow control, request packing, ack unpacking and registers
////////////////////
`timescale 1ns/1ps

module roce_stack
    import roce_pkg::*;
(
    input  logic                       nclk,
    input  logic                       arst_n,

    // User send queue
    input  logic                       sq_valid,
    output logic                       sq_ready,
    input  rdma_opcode_e               sq_opcode,
    input  logic [RDMA_QPN_BITS-1:0]   sq_qpn,
    input  logic [RDMA_VADDR_BITS-1:0] sq_vaddr,
    input  logic [RDMA_LEN_BITS-1:0]   sq_len,
    input  logic                       sq_last,

    // Protocol engine request
    output logic                       req_valid,
    input  logic                       req_ready,
    output logic [RDMA_REQ_BITS-1:0]   req_data,

    // Protocol engine ack
    input  logic                       ack_valid,
    output logic                       ack_ready,
    input  logic [RDMA_ACK_BITS-1:0]   ack_data,

    // User completion
    output logic                       cpl_valid,
    input  logic                       cpl_ready,
    output ack_opcode_e                cpl_opcode,
    output logic [RDMA_QPN_BITS-1:0]   cpl_qpn,
    output logic                       cpl_last,

    // Config
    input  logic                       cfg_wr_en,
    input  reg_addr_e                  cfg_addr,
    input  logic [CFG_DATA_BITS-1:0]   cfg_wdata,
    output logic [CFG_DATA_BITS-1:0]   cfg_rdata
);

    sq_intf sq_if ();

    logic [CREDIT_BITS-1:0] credit_limit;
    logic                   credit_return;
    logic                   req_issued;
    logic                   ack_seen;
    logic                   nak_seen;

    ////////////////////
    // SQ path
    rdma_flow_ctrl i_flow (
        .nclk          (nclk),
        .arst_n        (arst_n),
        .sq_valid      (sq_valid),
        .sq_ready      (sq_ready),
        .sq_opcode     (sq_opcode),
        .sq_qpn        (sq_qpn),
        .sq_vaddr      (sq_vaddr),
        .sq_len        (sq_len),
        .sq_last       (sq_last),
        .sq            (sq_if.src),
        .credit_limit  (credit_limit),
        .credit_return (credit_return),
        .req_issued    (req_issued)
    );

    sq_packer i_packer (
        .nclk      (nclk),
        .arst_n    (arst_n),
        .sq        (sq_if.dst),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_data  (req_data)
    );

    ////////////////////
    // Ack path and credits back
    ack_unpacker i_ack (
        .nclk          (nclk),
        .arst_n        (arst_n),
        .ack_valid     (ack_valid),
        .ack_ready     (ack_ready),
        .ack_data      (ack_data),
        .cpl_valid     (cpl_valid),
        .cpl_ready     (cpl_ready),
        .cpl_opcode    (cpl_opcode),
        .cpl_qpn       (cpl_qpn),
        .cpl_last      (cpl_last),
        .credit_return (credit_return),
        .ack_seen      (ack_seen),
        .nak_seen      (nak_seen)
    );

    stack_regs i_regs (
        .nclk         (nclk),
        .arst_n       (arst_n),
        .cfg_wr_en    (cfg_wr_en),
        .cfg_addr     (cfg_addr),
        .cfg_wdata    (cfg_wdata),
        .cfg_rdata    (cfg_rdata),
        .credit_limit (credit_limit),
        .req_issued   (req_issued),
        .ack_seen     (ack_seen),
        .nak_seen     (nak_seen)
    );

endmodule

// ==== tests/roce_stack_checker.sv ====
////////////////////
// Handshake assertions bound into roce_stack
////////////////////
`timescale 1ns/1ps

module roce_stack_checker
    import roce_pkg::*;
(
    input logic                     nclk,
    input logic                     arst_n,
    input logic                     sq_ready,
    input logic                     req_valid,
    input logic                     req_ready,
    input logic [RDMA_REQ_BITS-1:0] req_data,
    input logic                     cpl_valid,
    input logic                     cpl_ready,
    input ack_opcode_e              cpl_opcode,
    input logic [RDMA_QPN_BITS-1:0] cpl_qpn,
    input logic                     cpl_last
);

    int assert_fails = 0;

    // Stalled request word holds
    req_hold: assert property (@(posedge nclk) disable iff (!arst_n)
        req_valid && !req_ready |=> req_valid && $stable(req_data))
        else begin
            $error("request word changed while req_ready was low");
            assert_fails++;
        end

    // Stalled completion holds
    cpl_hold: assert property (@(posedge nclk) disable iff (!arst_n)
        cpl_valid && !cpl_ready |=> cpl_valid && $stable({cpl_opcode, cpl_qpn, cpl_last}))
        else begin
            $error("completion changed while cpl_ready was low");
            assert_fails++;
        end

    // No new command while the packer is blocked
    sq_block: assert property (@(posedge nclk) disable iff (!arst_n)
        req_valid && !req_ready |-> !sq_ready)
        else begin
            $error("sq_ready high while the request word was stalled");
            assert_fails++;
        end

endmodule

bind roce_stack roce_stack_checker i_checker (
    .nclk       (nclk),
    .arst_n     (arst_n),
    .sq_ready   (sq_ready),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req_data   (req_data),
    .cpl_valid  (cpl_valid),
    .cpl_ready  (cpl_ready),
    .cpl_opcode (cpl_opcode),
    .cpl_qpn    (cpl_qpn),
    .cpl_last   (cpl_last)
);

// ==== tests/tb_roce_stack.sv ====
////////////////////
// Testbench for the RoCE command and ack glue
// Table of commands and acks, random back-pressure
////////////////////
`timescale 1ns/1ps

module tb_roce_stack
    import roce_pkg::*;
();

    localparam int TABLE_LEN      = 8;
    localparam int CREDIT_CMDS    = 5;
    localparam int TIMEOUT_CYCLES = 20 * TABLE_LEN + 200;

    typedef struct packed {
        rdma_opcode_e             op;
        logic [RDMA_QPN_BITS-1:0] qpn;
        logic                     last;
        ack_opcode_e              ack_op;
    } entry_t;

    typedef struct packed {
        int unsigned                idx;
        logic [RDMA_VADDR_BITS-1:0] vaddr;
        logic [RDMA_LEN_BITS-1:0]   len;
    } cmd_t;

    // Command fields and the ack the engine sends back for it
    localparam entry_t STIM [TABLE_LEN] = '{
        '{RC_WRITE,     24'h000011, 1'b0, ACK_POS},
        '{RC_WRITE,     24'h000011, 1'b1, ACK_POS},
        '{RC_READ,      24'h0A0B0C, 1'b1, ACK_NAK},
        '{RC_SEND,      24'h123456, 1'b0, ACK_POS},
        '{RC_SEND,      24'h123456, 1'b1, ACK_NAK},
        '{RC_WRITE_IMM, 24'hFFFFFF, 1'b1, ACK_POS},
        '{RC_READ,      24'h800001, 1'b0, ACK_POS},
        '{RC_WRITE_IMM, 24'h000000, 1'b1, ACK_NAK}
    };

    logic nclk, arst_n, sq_valid, sq_ready, sq_last, req_valid, req_ready;
    logic ack_valid, ack_ready, cpl_valid, cpl_ready, cpl_last, cfg_wr_en;
    rdma_opcode_e               sq_opcode;
    ack_opcode_e                cpl_opcode;
    reg_addr_e                  cfg_addr;
    logic [RDMA_QPN_BITS-1:0]   sq_qpn, cpl_qpn;
    logic [RDMA_VADDR_BITS-1:0] sq_vaddr;
    logic [RDMA_LEN_BITS-1:0]   sq_len;
    logic [RDMA_REQ_BITS-1:0]   req_data;
    logic [RDMA_ACK_BITS-1:0]   ack_data;
    logic [CFG_DATA_BITS-1:0]   cfg_wdata, cfg_rdata;

    cmd_t                     cmd_q[$];
    logic [RDMA_REQ_BITS-1:0] exp_req_q[$];
    int unsigned              ack_q[$];
    int unsigned              exp_cpl_q[$];
    bit                       req_stall, cpl_stall;
    int                       errors, checks, tests, accepted, naks_sent, cycles;

    roce_stack i_dut (.*);

    initial begin
        nclk = 1'b0;
        forever #50 nclk = ~nclk;
    end

    function automatic logic [RDMA_REQ_BITS-1:0] expected_request(cmd_t c);
        logic [RDMA_REQ_BITS-1:0] w;
        w = RDMA_REQ_BITS'(STIM[c.idx].op) << REQ_OPCODE_LSB;
        w |= RDMA_REQ_BITS'(STIM[c.idx].qpn) << REQ_QPN_LSB;
        w |= RDMA_REQ_BITS'(STIM[c.idx].last) << REQ_LAST_LSB;
        w |= RDMA_REQ_BITS'(c.vaddr) << REQ_VADDR_LSB;
        w |= RDMA_REQ_BITS'(c.len) << REQ_LEN_LSB;
        return w;
    endfunction

    // Bits above the last flag carry an index tag the DUT must ignore
    function automatic logic [RDMA_ACK_BITS-1:0] ack_word(int unsigned idx);
        logic [RDMA_ACK_BITS-1:0] w;
        w = RDMA_ACK_BITS'(STIM[idx].ack_op) << ACK_OPCODE_LSB;
        w |= RDMA_ACK_BITS'(STIM[idx].qpn) << ACK_QPN_LSB;
        w |= RDMA_ACK_BITS'(STIM[idx].last) << ACK_LAST_LSB;
        w |= RDMA_ACK_BITS'(idx + 1) << 40;
        return w;
    endfunction

    task automatic check_value(string what, logic [RDMA_REQ_BITS-1:0] got,
                               logic [RDMA_REQ_BITS-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic report_test(string name, int start_errors);
        tests++;
        if (errors == start_errors) $display("%s: ok", name);
        else $display("%s: %0d errors", name, errors - start_errors);
    endtask

    task automatic queue_command(int unsigned idx);
        cmd_t c;
        c.idx   = idx;
        c.vaddr = {16'($urandom()), $urandom()};
        c.len   = $urandom();
        cmd_q.push_back(c);
    endtask

    task automatic queue_ack(int unsigned idx);
        ack_q.push_back(idx);
        if (STIM[idx].ack_op == ACK_NAK) naks_sent++;
    endtask

    task automatic write_reg(reg_addr_e addr, logic [CFG_DATA_BITS-1:0] data);
        @(negedge nclk);
        cfg_wr_en = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(negedge nclk);
        cfg_wr_en = 1'b0;
    endtask

    task automatic read_reg(reg_addr_e addr, output logic [CFG_DATA_BITS-1:0] data);
        @(negedge nclk);
        cfg_addr = addr;
        #1;
        data = cfg_rdata;
    endtask

    ////////////////////
    // Stream driver and monitor run once per falling edge
    initial begin
        int unsigned idx;
        forever begin
            @(negedge nclk);
            req_ready = req_stall ? (($urandom() % 3) != 0) : 1'b1;
            cpl_ready = cpl_stall ? (($urandom() % 2) != 0) : 1'b1;
            sq_valid  = (cmd_q.size() > 0);
            if (sq_valid) begin
                sq_opcode = STIM[cmd_q[0].idx].op;
                sq_qpn    = STIM[cmd_q[0].idx].qpn;
                sq_last   = STIM[cmd_q[0].idx].last;
                sq_vaddr  = cmd_q[0].vaddr;
                sq_len    = cmd_q[0].len;
            end
            ack_valid = (ack_q.size() > 0);
            if (ack_valid) ack_data = ack_word(ack_q[0]);
            // Let the combinational readies settle
            #1;
            if (sq_valid && sq_ready) begin
                exp_req_q.push_back(expected_request(cmd_q.pop_front()));
                accepted++;
            end
            if (req_valid && req_ready) begin
                if (exp_req_q.size() == 0) begin
                    errors++;
                    $display("Request word %0h appeared with no command accepted", req_data);
                end else begin
                    check_value("req_data", req_data, exp_req_q.pop_front());
                end
            end
            // A stalled completion blocks new acks
            if (cpl_valid && !cpl_ready) begin
                check_value("ack_ready while completion stalled", ack_ready, 0);
            end
            if (ack_valid && ack_ready) exp_cpl_q.push_back(ack_q.pop_front());
            if (cpl_valid && cpl_ready) begin
                if (exp_cpl_q.size() == 0) begin
                    errors++;
                    $display("Completion for qpn %0h appeared with no ack accepted", cpl_qpn);
                end else begin
                    idx = exp_cpl_q.pop_front();
                    check_value("cpl_opcode", cpl_opcode, STIM[idx].ack_op);
                    check_value("cpl_qpn", cpl_qpn, STIM[idx].qpn);
                    check_value("cpl_last", cpl_last, STIM[idx].last);
                end
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge nclk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failed");
        $finish;
    end

    ////////////////////
    // Test sequence
    initial begin
        logic [CFG_DATA_BITS-1:0] rd;
        logic [CFG_DATA_BITS-1:0] rd_nak;
        int                       start_errors;
        int                       base;
        int                       expect_n;
        void'($urandom(32'h7079_eecb));
        arst_n    = 1'b0;
        sq_valid  = 1'b0;
        sq_opcode = RC_SEND;
        sq_qpn    = '0;
        sq_vaddr  = '0;
        sq_len    = '0;
        sq_last   = 1'b0;
        req_ready = 1'b0;
        ack_valid = 1'b0;
        ack_data  = '0;
        cpl_ready = 1'b0;
        cfg_wr_en = 1'b0;
        cfg_addr  = REG_CREDIT_LIMIT;
        cfg_wdata = '0;
        req_stall = 1'b0;
        cpl_stall = 1'b0;
        repeat (4) @(posedge nclk);
        @(negedge nclk);
        arst_n = 1'b1;

        start_errors = errors;
        #2;
        check_value("req_valid after reset", req_valid, 0);
        check_value("cpl_valid after reset", cpl_valid, 0);
        check_value("sq_ready after reset", sq_ready, 1);
        read_reg(REG_CREDIT_LIMIT, rd);
        check_value("credit limit after reset", rd, MAX_OUTSTANDING);
        for (int a = 1; a < 4; a++) begin
            read_reg(reg_addr_e'(a), rd);
            check_value("counter after reset", rd, 0);
        end
        report_test("reset values", start_errors);

        start_errors = errors;
        req_stall = 1'b1;
        for (int i = 0; i < TABLE_LEN; i++) queue_command(i);
        while (accepted < TABLE_LEN || exp_req_q.size() > 0) @(negedge nclk);
        req_stall = 1'b0;
        report_test("request packing", start_errors);

        start_errors = errors;
        cpl_stall = 1'b1;
        for (int i = 0; i < TABLE_LEN; i++) queue_ack(i);
        while (ack_q.size() > 0 || exp_cpl_q.size() > 0) @(negedge nclk);
        cpl_stall = 1'b0;
        report_test("completions", start_errors);

        start_errors = errors;
        write_reg(REG_CREDIT_LIMIT, 3);
        base = accepted;
        for (int i = 0; i < CREDIT_CMDS; i++) queue_command(i);
        while (accepted < base + 3) @(negedge nclk);
        repeat (10) @(negedge nclk);
        #2;
        checks++;
        if (accepted != base + 3 || sq_ready !== 1'b0) begin
            errors++;
            $display("ERROR %0t: limit 3 let %0d requests out, sq_ready %b",
                     $time, accepted - base, sq_ready);
        end
        for (int i = 0; i < CREDIT_CMDS; i++) begin
            queue_ack(i);
            while (ack_q.size() > 0) @(negedge nclk);
            repeat (5) @(negedge nclk);
            expect_n = (i + 4 < CREDIT_CMDS) ? i + 4 : CREDIT_CMDS;
            check_value("requests admitted after ack", accepted - base, expect_n);
        end
        write_reg(REG_CREDIT_LIMIT, 20);
        read_reg(REG_CREDIT_LIMIT, rd);
        check_value("clamped credit limit", rd, MAX_OUTSTANDING);
        while (exp_cpl_q.size() > 0 || exp_req_q.size() > 0) @(negedge nclk);
        report_test("credit stall", start_errors);

        start_errors = errors;
        read_reg(REG_REQ_COUNT, rd);
        check_value("request count", rd, TABLE_LEN + CREDIT_CMDS);
        read_reg(REG_NAK_COUNT, rd_nak);
        check_value("nak count", rd_nak, naks_sent);
        read_reg(REG_ACK_COUNT, rd);
        check_value("ack plus nak count", rd + rd_nak, TABLE_LEN + CREDIT_CMDS);
        report_test("counters", start_errors);

        $display("Summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
                 tests, checks, errors, i_dut.i_checker.assert_fails);
        if (errors == 0 && i_dut.i_checker.assert_fails == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
logic/roce_pkg.sv
logic/sq_intf.sv
logic/rdma_flow_ctrl.sv
logic/sq_packer.sv
logic/ack_unpacker.sv
logic/stack_regs.sv
logic/roce_stack.sv
tests/roce_stack_checker.sv
tests/tb_roce_stack.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_roce_stack
FILELIST = src.f
OBJ_DIR  = obj_dir
SIM_ARGS = +verilator+error+limit+100
PASS_MSG = Test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
